//--- logic/UsiPkg.sv
// Shared USI bus types and CSR map, assuming 32-bit data and a 4-bit block field at bits 19 to 16
package UsiPkg;

	// --------------------------------------
	// Bus widths
	// --------------------------------------
	// Bus address width
	localparam int lpBusAdrsBit = 32;
	// USI data width
	localparam int lpUsiBusWidth = 32;
	// Block address field, up to 16 blocks
	localparam int lpBlockAdrsMap = 4;
	// CSR offset inside one block
	localparam int lpCsrAdrsWidth = 16;
	// Unused upper address bits
	localparam int lpRsvAdrsWidth = lpBusAdrsBit - lpBlockAdrsMap - lpCsrAdrsWidth;

	// --------------------------------------
	// Bus address split
	// --------------------------------------
	// Block lands on address bits 19 to 16
	typedef struct packed {
		logic [lpRsvAdrsWidth-1:0] reserved;
		logic [lpBlockAdrsMap-1:0] block;
		logic [lpCsrAdrsWidth-1:0] csr;
	} usiAdrsT;

	// --------------------------------------
	// Command and return words
	// --------------------------------------
	// One master command, we and re never high together
	typedef struct packed {
		usiAdrsT adrs;
		logic [lpUsiBusWidth-1:0] wd;
		logic we;
		logic re;
	} usiCmdT;

	// Block side command, block field already decoded
	typedef struct packed {
		logic [lpCsrAdrsWidth-1:0] csr;
		logic [lpUsiBusWidth-1:0] wd;
		logic we;
		logic re;
	} usiSlvCmdT;

	// Read return with its valid strobe
	typedef struct packed {
		logic [lpUsiBusWidth-1:0] rd;
		logic vd;
	} usiRetT;

	// --------------------------------------
	// CSR offsets
	// --------------------------------------
	// GPIO block
	localparam logic [lpCsrAdrsWidth-1:0] lpGpioLed = 16'h0000;
	localparam logic [lpCsrAdrsWidth-1:0] lpGpioIn = 16'h0004;
	localparam logic [lpCsrAdrsWidth-1:0] lpGpioScratch = 16'h0008;
	// Timer block
	localparam logic [lpCsrAdrsWidth-1:0] lpTimCtrl = 16'h0000;
	localparam logic [lpCsrAdrsWidth-1:0] lpTimCompare = 16'h0004;
	localparam logic [lpCsrAdrsWidth-1:0] lpTimCount = 16'h0008;
	localparam logic [lpCsrAdrsWidth-1:0] lpTimIrqClr = 16'h000C;

endpackage

//--- logic/UsiMasterSelect.sv
// Picks one of two masters by the msSel level, strobes of the other master are lost without notice
`timescale 1ns/1ps

module UsiMasterSelect
(
	// Clock and reset
	input  logic sysClk,
	input  logic rstN,
	// Master select level
	// 0 picks the local port, 1 the external port
	input  logic msSel,
	// Local controller command
	input  UsiPkg::usiCmdT mcbCmd,
	// External CPU command
	input  UsiPkg::usiCmdT extCmd,
	// Registered command toward the bus
	output UsiPkg::usiCmdT selCmd
);

	// --------------------------------------
	// Master mux
	// --------------------------------------
	// Combinational pick before the register
	UsiPkg::usiCmdT muxCmd;

	always_comb
	begin
		// Unselected master is simply ignored
		if (msSel)
		begin
			muxCmd = extCmd;
		end
		else
		begin
			muxCmd = mcbCmd;
		end
	end

	// --------------------------------------
	// Command register
	// --------------------------------------
	// One cycle of latency, edge 1 after the strobe
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			// Strobes low and fields zero out of reset
			selCmd <= '0;
		end
		else
		begin
			selCmd <= muxCmd;
		end
	end

endmodule

//--- logic/UsiBus.sv
// Block decode on adrs.block, unmatched blocks get no response and no error strobe
`timescale 1ns/1ps

module UsiBus #(
	// Block address of the GPIO block
	parameter logic [UsiPkg::lpBlockAdrsMap-1:0] pGpioAdrsMap = 4'h1,
	// Block address of the timer block
	parameter logic [UsiPkg::lpBlockAdrsMap-1:0] pTimerAdrsMap = 4'h2
)(
	// Clock and reset
	input  logic sysClk,
	input  logic rstN,
	// Selected master command
	input  UsiPkg::usiCmdT selCmd,
	// Per block commands
	output UsiPkg::usiSlvCmdT gpioCmd,
	output UsiPkg::usiSlvCmdT timerCmd,
	// Per block returns
	input  UsiPkg::usiRetT gpioRet,
	input  UsiPkg::usiRetT timerRet,
	// Return toward both masters
	output UsiPkg::usiRetT rdRet
);

	// --------------------------------------
	// Block decode
	// --------------------------------------
	// Address match per block
	logic gpioHit;
	logic timerHit;

	// Reserved address bits are not decoded
	assign gpioHit = (selCmd.adrs.block == pGpioAdrsMap);
	assign timerHit = (selCmd.adrs.block == pTimerAdrsMap);

	// Shared slave command builder
	// csr and wd go to every block, strobes only on a hit
	function automatic UsiPkg::usiSlvCmdT toSlave(
		input UsiPkg::usiCmdT cmd,
		input logic hit
	);
		UsiPkg::usiSlvCmdT slv;
		slv.csr = cmd.adrs.csr;
		slv.wd = cmd.wd;
		slv.we = cmd.we & hit;
		slv.re = cmd.re & hit;
		return slv;
	endfunction

	// --------------------------------------
	// Command fan-out register
	// --------------------------------------
	// Edge 2 after the master strobe
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			gpioCmd <= '0;
			timerCmd <= '0;
		end
		else
		begin
			gpioCmd <= toSlave(selCmd, gpioHit);
			timerCmd <= toSlave(selCmd, timerHit);
		end
	end

	// --------------------------------------
	// Read return path
	// --------------------------------------
	// At most one block answers per cycle
	// since only one block was strobed
	UsiPkg::usiRetT retMux;

	always_comb
	begin
		retMux.vd = gpioRet.vd | timerRet.vd;
		// GPIO first, timer otherwise
		if (gpioRet.vd)
		begin
			retMux.rd = gpioRet.rd;
		end
		else
		begin
			retMux.rd = timerRet.rd;
		end
	end

	// Edge 4 after a read strobe
	// vd is a single cycle pulse
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			rdRet <= '0;
		end
		else
		begin
			rdRet <= retMux;
		end
	end

endmodule

//--- logic/GpioBlock.sv
// GPIO registers with an 8-bit LED port and 8 inputs, the inputs may be asynchronous to sysClk
`timescale 1ns/1ps

module GpioBlock
(
	// Clock and reset
	input  logic sysClk,
	input  logic rstN,
	// Decoded bus command
	input  UsiPkg::usiSlvCmdT cmd,
	// Read return, one cycle after re
	output UsiPkg::usiRetT ret,
	// Pins
	input  logic [7:0] gpioIn,
	output logic [7:0] led
);

	// --------------------------------------
	// Registers
	// --------------------------------------
	// LED register at 0x0
	logic [7:0] ledReg;
	// Scratch register at 0x8
	logic [UsiPkg::lpUsiBusWidth-1:0] scratchReg;
	// Two stage input synchroniser
	logic [7:0] inMeta;
	logic [7:0] inSync;
	// Read data before the return register
	logic [UsiPkg::lpUsiBusWidth-1:0] rdMux;

	// Write side, edge 3 after the master strobe
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			ledReg <= '0;
			scratchReg <= '0;
		end
		else if (cmd.we)
		begin
			case (cmd.csr)
				UsiPkg::lpGpioLed:
				begin
					// Only the low byte drives pins
					ledReg <= cmd.wd[7:0];
				end
				UsiPkg::lpGpioScratch:
				begin
					scratchReg <= cmd.wd;
				end
				default:
				begin
					// Input port and unmapped offsets ignore writes
				end
			endcase
		end
	end

	// Input synchroniser
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			inMeta <= '0;
			inSync <= '0;
		end
		else
		begin
			inMeta <= gpioIn;
			inSync <= inMeta;
		end
	end

	// --------------------------------------
	// Read side
	// --------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (cmd.csr)
			// Byte values are zero-extended
			UsiPkg::lpGpioLed: rdMux[7:0] = ledReg;
			UsiPkg::lpGpioIn: rdMux[7:0] = inSync;
			UsiPkg::lpGpioScratch: rdMux = scratchReg;
			default: rdMux = '0;
		endcase
	end

	// Unmapped offsets still answer, with zero
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			ret <= '0;
		end
		else
		begin
			ret.vd <= cmd.re;
			ret.rd <= rdMux;
		end
	end

	assign led = ledReg;

endmodule

//--- logic/TimerBlock.sv
// Free running match timer, the count is read only and timerIrq stays high until cleared by software
`timescale 1ns/1ps

module TimerBlock
(
	// Clock and reset
	input  logic sysClk,
	input  logic rstN,
	// Decoded bus command
	input  UsiPkg::usiSlvCmdT cmd,
	// Read return, one cycle after re
	output UsiPkg::usiRetT ret,
	// Level interrupt
	output logic timerIrq
);

	// --------------------------------------
	// Registers
	// --------------------------------------
	// Control bit 0 enables counting
	logic timEn;
	// Match value
	logic [UsiPkg::lpUsiBusWidth-1:0] compareReg;
	// Running count
	logic [UsiPkg::lpUsiBusWidth-1:0] countReg;
	// Latched interrupt
	logic irqReg;
	// Count hit the compare value
	logic match;
	// Write to the IRQ clear offset
	logic irqClr;
	// Read data before the return register
	logic [UsiPkg::lpUsiBusWidth-1:0] rdMux;

	assign match = timEn && (countReg == compareReg);
	assign irqClr = cmd.we && (cmd.csr == UsiPkg::lpTimIrqClr);

	// Control writes
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			timEn <= 1'b0;
			compareReg <= '0;
		end
		else if (cmd.we)
		begin
			if (cmd.csr == UsiPkg::lpTimCtrl)
			begin
				timEn <= cmd.wd[0];
			end
			if (cmd.csr == UsiPkg::lpTimCompare)
			begin
				compareReg <= cmd.wd;
			end
		end
	end

	// --------------------------------------
	// Counter and interrupt
	// --------------------------------------
	// Wraps to zero on a match, holds while disabled
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			countReg <= '0;
		end
		else if (match)
		begin
			countReg <= '0;
		end
		else if (timEn)
		begin
			countReg <= countReg + 1'b1;
		end
	end

	// Match in the clear cycle keeps the IRQ set
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			irqReg <= 1'b0;
		end
		else if (match)
		begin
			irqReg <= 1'b1;
		end
		else if (irqClr)
		begin
			irqReg <= 1'b0;
		end
	end

	// --------------------------------------
	// Read side
	// --------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (cmd.csr)
			UsiPkg::lpTimCtrl: rdMux[0] = timEn;
			UsiPkg::lpTimCompare: rdMux = compareReg;
			UsiPkg::lpTimCount: rdMux = countReg;
			// IRQ clear and the rest read as zero
			default: rdMux = '0;
		endcase
	end

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			ret <= '0;
		end
		else
		begin
			ret.vd <= cmd.re;
			ret.rd <= rdMux;
		end
	end

	assign timerIrq = irqReg;

endmodule

//--- logic/Processer.sv
// System controller top on one clock, block maps must be distinct nonzero 4-bit values
`timescale 1ns/1ps

module Processer #(
	// Block address map
	parameter logic [UsiPkg::lpBlockAdrsMap-1:0] pGpioAdrsMap = 4'h1,
	parameter logic [UsiPkg::lpBlockAdrsMap-1:0] pTimerAdrsMap = 4'h2
)(
	// Clock and reset
	input  logic sysClk,
	input  logic rstN,
	// Master ports and select level
	input  logic msSel,
	input  UsiPkg::usiCmdT mcbCmd,
	input  UsiPkg::usiCmdT extCmd,
	// GPIO pins
	input  logic [7:0] gpioIn,
	// Read return shared by both masters
	output UsiPkg::usiRetT rdRet,
	output logic [7:0] led,
	output logic timerIrq
);

	// --------------------------------------
	// Input side
	// --------------------------------------
	UsiPkg::usiCmdT selCmd;

	UsiMasterSelect UsiMasterSelect_i (
		.sysClk (sysClk),
		.rstN   (rstN),
		.msSel  (msSel),
		.mcbCmd (mcbCmd),
		.extCmd (extCmd),
		.selCmd (selCmd)
	);

	// --------------------------------------
	// Bus decode and return path
	// --------------------------------------
	UsiPkg::usiSlvCmdT gpioCmd;
	UsiPkg::usiSlvCmdT timerCmd;
	UsiPkg::usiRetT gpioRet;
	UsiPkg::usiRetT timerRet;

	UsiBus #(
		.pGpioAdrsMap  (pGpioAdrsMap),
		.pTimerAdrsMap (pTimerAdrsMap)
	) UsiBus_i (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.selCmd   (selCmd),
		.gpioCmd  (gpioCmd),
		.timerCmd (timerCmd),
		.gpioRet  (gpioRet),
		.timerRet (timerRet),
		.rdRet    (rdRet)
	);

	// --------------------------------------
	// Register blocks
	// --------------------------------------
	GpioBlock GpioBlock_i (
		.sysClk (sysClk),
		.rstN   (rstN),
		.cmd    (gpioCmd),
		.ret    (gpioRet),
		.gpioIn (gpioIn),
		.led    (led)
	);

	TimerBlock TimerBlock_i (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.cmd      (timerCmd),
		.ret      (timerRet),
		.timerIrq (timerIrq)
	);

endmodule

//--- tb/UsiBus_chk.sv
// Bus protocol assertions bound into every UsiBus instance, valid only on the single system clock
`timescale 1ns/1ps

module UsiBusChk
(
	input  logic sysClk,
	input  logic rstN,
	input  UsiPkg::usiSlvCmdT gpioCmd,
	input  UsiPkg::usiSlvCmdT timerCmd,
	input  UsiPkg::usiRetT gpioRet,
	input  UsiPkg::usiRetT timerRet,
	input  UsiPkg::usiRetT rdRet
);

	// --------------------------------------
	// Decode
	// --------------------------------------
	// Never two blocks strobed at once
	assert property (@(posedge sysClk) disable iff (!rstN)
		!((gpioCmd.we | gpioCmd.re) && (timerCmd.we | timerCmd.re)))
	else $error("Both blocks strobed in one cycle");

	// --------------------------------------
	// Return path
	// --------------------------------------
	// A return needs a block answer one cycle before
	assert property (@(posedge sysClk) disable iff (!rstN)
		rdRet.vd |-> $past(gpioRet.vd | timerRet.vd))
	else $error("rdRet.vd without a block return");

	// Sync reset clears strobes at the next edge
	assert property (@(posedge sysClk)
		!rstN |=> !(gpioCmd.we | gpioCmd.re | timerCmd.we | timerCmd.re | rdRet.vd))
	else $error("Strobe high during reset");

endmodule

bind UsiBus UsiBusChk UsiBusChk_i (
	.sysClk   (sysClk),
	.rstN     (rstN),
	.gpioCmd  (gpioCmd),
	.timerCmd (timerCmd),
	.gpioRet  (gpioRet),
	.timerRet (timerRet),
	.rdRet    (rdRet)
);

//--- tb/ProcesserTb.sv
// Table driven testbench for Processer that assumes the default block maps and drives 1 ns after each rising edge
`timescale 1ns/1ps

module ProcesserTb;

	// --------------------------------------
	// Stimulus and expected data types
	// --------------------------------------
	// One table row
	// Port 0 drives mcbCmd and port 1 drives extCmd
	typedef struct packed {
		logic msSel;
		logic port;
		logic we;
		logic re;
		logic [3:0] block;
		logic [15:0] csr;
		logic [31:0] wd;
		logic [31:0] expRd;
		logic chk;
		logic bound;
	} stimRowT;

	// Pending read
	// With bound set the value is an upper limit
	typedef struct packed {
		logic [31:0] val;
		logic bound;
	} expRdT;

	// CSR offsets from the shared map
	localparam logic [15:0] csrLed = UsiPkg::lpGpioLed;
	localparam logic [15:0] csrIn = UsiPkg::lpGpioIn;
	localparam logic [15:0] csrScratch = UsiPkg::lpGpioScratch;
	localparam logic [15:0] csrCtrl = UsiPkg::lpTimCtrl;
	localparam logic [15:0] csrCompare = UsiPkg::lpTimCompare;
	localparam logic [15:0] csrCount = UsiPkg::lpTimCount;
	localparam logic [15:0] csrIrqClr = UsiPkg::lpTimIrqClr;

	// DUT signals
	logic sysClk;
	logic rstN;
	logic msSel;
	UsiPkg::usiCmdT mcbCmd;
	UsiPkg::usiCmdT extCmd;
	logic [7:0] gpioIn;
	UsiPkg::usiRetT rdRet;
	logic [7:0] led;
	logic timerIrq;

	// Bookkeeping
	stimRowT stimTab[$];
	expRdT expQ[$];
	int valErr;
	int toErr;
	integer seed;
	logic [7:0] gpioVal;
	logic [3:0] gpioBlk;
	logic [3:0] timerBlk;

	Processer Processer_i (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.msSel    (msSel),
		.mcbCmd   (mcbCmd),
		.extCmd   (extCmd),
		.gpioIn   (gpioIn),
		.rdRet    (rdRet),
		.led      (led),
		.timerIrq (timerIrq)
	);

	// 8 ns clock
	initial
	begin
		sysClk = 1'b0;
		forever
		begin
			#4 sysClk = ~sysClk;
		end
	end

	// --------------------------------------
	// Helpers
	// --------------------------------------
	function automatic stimRowT mkRow(input logic ms, input logic port, input logic we,
		input logic re, input logic [3:0] block, input logic [15:0] csr,
		input logic [31:0] wd, input logic [31:0] expRd, input logic chk, input logic bound);
		stimRowT r;
		r = {ms, port, we, re, block, csr, wd, expRd, chk, bound};
		return r;
	endfunction

	// Drives one command while the other port idles
	task automatic applyRow(input stimRowT r);
		UsiPkg::usiCmdT c;
		expRdT e;
		@(posedge sysClk);
		#1;
		c = '0;
		c.adrs.block = r.block;
		c.adrs.csr = r.csr;
		c.wd = r.wd;
		c.we = r.we;
		c.re = r.re;
		msSel = r.msSel;
		mcbCmd = r.port ? '0 : c;
		extCmd = r.port ? c : '0;
		// Only a selected, mapped read gets queued
		if (r.re && r.chk)
		begin
			e.val = r.expRd;
			e.bound = r.bound;
			expQ.push_back(e);
		end
	endtask

	// Strobes low on both ports
	task automatic applyIdle();
		@(posedge sysClk);
		#1;
		mcbCmd = '0;
		extCmd = '0;
	endtask

	// Waits for all pending reads
	task automatic waitDrain(input int limit);
		int n;
		n = 0;
		while (expQ.size() != 0 && n < limit)
		begin
			@(negedge sysClk);
			n++;
		end
		if (expQ.size() != 0)
		begin
			$display("Timeout: %0d read responses never arrived", expQ.size());
			toErr++;
			expQ.delete();
		end
	endtask

	// Waits for timerIrq to reach a level
	task automatic waitIrq(input logic level, input int limit);
		int n;
		n = 0;
		while (timerIrq !== level && n < limit)
		begin
			@(negedge sysClk);
			n++;
		end
		if (timerIrq !== level)
		begin
			$display("Timeout: timerIrq did not go to %0d within %0d cycles", level, limit);
			toErr++;
		end
	endtask

	// --------------------------------------
	// Read return monitor
	// --------------------------------------
	// Sampled on the falling edge away from the drive time
	always @(negedge sysClk)
	begin
		expRdT e;
		if (rstN && rdRet.vd)
		begin
			if (expQ.size() == 0)
			begin
				$display("Read response 0x%08h arrived with no read pending", rdRet.rd);
				valErr++;
			end
			else
			begin
				e = expQ.pop_front();
				if (e.bound)
				begin
					assert (rdRet.rd <= e.val)
					else
					begin
						$display("ERR rdRet.rd got 0x%08h above limit 0x%08h", rdRet.rd, e.val);
						valErr++;
					end
				end
				else
				begin
					assert (rdRet.rd == e.val)
					else
					begin
						$display("ERR rdRet.rd got 0x%08h exp 0x%08h", rdRet.rd, e.val);
						valErr++;
					end
				end
			end
		end
	end

	// --------------------------------------
	// Main sequence
	// --------------------------------------
	initial
	begin
		valErr = 0;
		toErr = 0;
		seed = 32343;
		gpioVal = 8'($random(seed));
		// All inputs defined at time 0
		rstN = 1'b0;
		msSel = 1'b0;
		mcbCmd = '0;
		extCmd = '0;
		gpioIn = gpioVal;
		gpioBlk = Processer_i.pGpioAdrsMap;
		timerBlk = Processer_i.pTimerAdrsMap;
		repeat (10) @(posedge sysClk);
		#1;
		rstN = 1'b1;

		// Local writes and readback
		stimTab.push_back(mkRow(0, 0, 1, 0, gpioBlk, csrLed, 32'h123456A5, 0, 0, 0));
		stimTab.push_back(mkRow(0, 0, 1, 0, gpioBlk, csrScratch, 32'hCAFEF00D, 0, 0, 0));
		stimTab.push_back(mkRow(0, 0, 0, 1, gpioBlk, csrLed, 0, 32'h000000A5, 1, 0));
		stimTab.push_back(mkRow(0, 0, 0, 1, gpioBlk, csrScratch, 0, 32'hCAFEF00D, 1, 0));
		// External master with local port strobes dropped
		stimTab.push_back(mkRow(1, 1, 1, 0, gpioBlk, csrScratch, 32'h13579BDF, 0, 0, 0));
		stimTab.push_back(mkRow(1, 0, 1, 0, gpioBlk, csrScratch, 32'hDEADBEEF, 0, 0, 0));
		stimTab.push_back(mkRow(1, 0, 0, 1, gpioBlk, csrScratch, 0, 0, 0, 0));
		stimTab.push_back(mkRow(1, 1, 0, 1, gpioBlk, csrScratch, 0, 32'h13579BDF, 1, 0));
		stimTab.push_back(mkRow(0, 1, 1, 0, gpioBlk, csrLed, 32'h0000003C, 0, 0, 0));
		// Synchronised input port
		stimTab.push_back(mkRow(0, 0, 0, 1, gpioBlk, csrIn, 0, {24'h0, gpioVal}, 1, 0));
		// Back to back reads over both blocks
		stimTab.push_back(mkRow(0, 0, 1, 0, timerBlk, csrCompare, 32'h00000055, 0, 0, 0));
		stimTab.push_back(mkRow(0, 0, 0, 1, timerBlk, csrCompare, 0, 32'h00000055, 1, 0));
		stimTab.push_back(mkRow(0, 0, 0, 1, gpioBlk, csrLed, 0, 32'h000000A5, 1, 0));
		stimTab.push_back(mkRow(0, 0, 0, 1, timerBlk, csrCtrl, 0, 32'h00000000, 1, 0));
		stimTab.push_back(mkRow(1, 1, 0, 1, gpioBlk, csrScratch, 0, 32'h13579BDF, 1, 0));
		stimTab.push_back(mkRow(1, 1, 0, 1, timerBlk, csrCompare, 0, 32'h00000055, 1, 0));

		foreach (stimTab[i])
		begin
			applyRow(stimTab[i]);
		end
		applyIdle();
		waitDrain(20);
		// LED keeps the local write only
		assert (led == 8'hA5)
		else
		begin
			$display("ERR led got 0x%02h exp 0x%02h", led, 8'hA5);
			valErr++;
		end

		// Timer compare at 40 before the enable
		applyRow(mkRow(0, 0, 1, 0, timerBlk, csrCompare, 32'd40, 0, 0, 0));
		applyRow(mkRow(0, 0, 1, 0, timerBlk, csrCtrl, 32'h1, 0, 0, 0));
		applyIdle();
		waitIrq(1'b1, 200);
		applyRow(mkRow(0, 0, 0, 1, timerBlk, csrCount, 0, 32'd40, 1, 1));
		applyRow(mkRow(0, 0, 1, 0, timerBlk, csrIrqClr, 32'h0, 0, 0, 0));
		applyIdle();
		// Next match is about 40 cycles away
		waitIrq(1'b0, 8);
		applyRow(mkRow(0, 0, 1, 0, timerBlk, csrCtrl, 32'h0, 0, 0, 0));
		applyIdle();
		waitDrain(20);

		// Unmapped block 5 stays silent
		applyRow(mkRow(0, 0, 0, 1, 4'h5, 16'h0, 0, 0, 0, 0));
		applyIdle();
		repeat (10)
		begin
			@(negedge sysClk);
			assert (!rdRet.vd)
			else
			begin
				$display("Read of unmapped block 5 produced a response");
				valErr++;
			end
		end
		applyRow(mkRow(0, 0, 0, 1, gpioBlk, csrScratch, 0, 32'h13579BDF, 1, 0));
		applyIdle();
		waitDrain(20);

		$display("Errors: %0d value, %0d timeout", valErr, toErr);
		if (valErr == 0 && toErr == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
logic/UsiPkg.sv
logic/UsiMasterSelect.sv
logic/UsiBus.sv
logic/GpioBlock.sv
logic/TimerBlock.sv
logic/Processer.sv
tb/UsiBus_chk.sv
tb/ProcesserTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run ProcesserTb with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module ProcesserTb -o simv > build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 ; \
grep -qxF "Result: PASSED" sim.log 2>/dev/null \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }
